/* Makefile */
TOP = tb_board_io

.PHONY: all lint clean

all:
	verilator --binary --assert -f tb.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TEST PASS$$" sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* design/mfp_board_io.sv */
`timescale 1ns/1ns
`default_nettype none

module mfp_board_io
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mfp_io_pkg::switch_count-1:0] sw,
    input  logic [mfp_io_pkg::button_count-1:0] key, // active low.
    input  mfp_io_pkg::bus_req_t                bus_req,
    output mfp_io_pkg::bus_rsp_t                bus_rsp,
    output logic [9:0]                          ledr,
    output mfp_display_pkg::digit_bank_t        hex
);

    import mfp_io_pkg::*;
    import mfp_display_pkg::*;

    logic [switch_count-1:0]    sw_db;
    logic [button_count-1:0]    key_db;
    logic [red_led_count-1:0]   red_leds;
    logic [green_led_count-1:0] green_leds;
    logic [3:0]                 last_addr_nibble;
    nibble_bank_t               nibbles;

    mfp_switch_debouncer #(.WIDTH (switch_count + button_count)) i_debouncer (
        .clk    ( clk             ),
        .reset  ( reset           ),
        .sw_in  ( { ~key, sw }    ), // pressed key reads as 1.
        .sw_out ( { key_db, sw_db } )
    );

    mfp_gpio_registers i_gpio_registers (
        .clk              ( clk              ),
        .reset            ( reset            ),
        .bus_req          ( bus_req          ),
        .switches         ( sw_db            ),
        .buttons          ( key_db           ),
        .bus_rsp          ( bus_rsp          ),
        .red_leds         ( red_leds         ),
        .green_leds       ( green_leds       ),
        .last_addr_nibble ( last_addr_nibble )
    );

    assign ledr = { 1'b0, green_leds };

    // digit 5 down to digit 0.
    assign nibbles = { last_addr_nibble, { 2'b00, red_leds[17:16] },
                       red_leds[15:12], red_leds[11:8], red_leds[7:4], red_leds[3:0] };

    mfp_seven_segment_bank i_seven_segment_bank (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .nibbles ( nibbles ),
        .hex     ( hex     )
    );

endmodule

`default_nettype wire

/* design/mfp_display_pkg.sv */
`default_nettype none

package mfp_display_pkg;

    typedef logic [6:0] segments_t; // gfedcba, active low.

    localparam int digit_count = 6;

    typedef segments_t [digit_count-1:0] digit_bank_t;
    typedef logic [digit_count-1:0][3:0] nibble_bank_t;

    function automatic segments_t hex_to_segments(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'ha:    return 7'b0001000;
            4'hb:    return 7'b0000011; // lower case b.
            4'hc:    return 7'b1000110;
            4'hd:    return 7'b0100001; // lower case d.
            4'he:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

endpackage

`default_nettype wire

/* design/mfp_gpio_registers.sv */
`timescale 1ns/1ns
`default_nettype none

module mfp_gpio_registers
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  mfp_io_pkg::bus_req_t                 bus_req,
    input  logic [mfp_io_pkg::switch_count-1:0]  switches,
    input  logic [mfp_io_pkg::button_count-1:0]  buttons,
    output mfp_io_pkg::bus_rsp_t                 bus_rsp,
    output logic [mfp_io_pkg::red_led_count-1:0] red_leds,
    output logic [mfp_io_pkg::green_led_count-1:0] green_leds,
    output logic [3:0]                           last_addr_nibble
);

    import mfp_io_pkg::*;

    reg_sel_e    sel;
    logic [31:0] read_value;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------

    always_comb begin
        case (bus_req.addr)
            addr_red_leds:   sel = sel_red;
            addr_green_leds: sel = sel_green;
            addr_switches:   sel = sel_switch;
            addr_buttons:    sel = sel_button;
            default:         sel = sel_none;
        endcase
    end

    // ------------------------------------------------------------------------
    // led registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            red_leds   <= '0;
            green_leds <= '0;
        end else if (bus_req.valid && bus_req.write) begin
            case (sel)
                sel_red:   red_leds   <= bus_req.wdata[red_led_count-1:0];
                sel_green: green_leds <= bus_req.wdata[green_led_count-1:0];
                default:   ; // read-only and unmapped writes are dropped.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            last_addr_nibble <= 4'h0;
        else if (bus_req.valid)
            last_addr_nibble <= bus_req.addr[31:28];
    end

    // ------------------------------------------------------------------------
    // read response stage
    // ------------------------------------------------------------------------

    always_comb begin
        case (sel)
            sel_red:    read_value = 32'(red_leds);
            sel_green:  read_value = 32'(green_leds);
            sel_switch: read_value = 32'(switches);
            sel_button: read_value = 32'(buttons);
            default:    read_value = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= bus_req.valid && !bus_req.write;
    end

    always_ff @(posedge clk) begin
        rsp_rdata <= read_value;
    end

    assign bus_rsp.valid = rsp_valid;
    assign bus_rsp.rdata = rsp_rdata;

endmodule

`default_nettype wire

/* design/mfp_io_pkg.sv */
`default_nettype none

package mfp_io_pkg;

    // ------------------------------------------------------------------------
    // bus transaction types
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef enum logic [2:0] {
        sel_red,
        sel_green,
        sel_switch,
        sel_button,
        sel_none
    } reg_sel_e;

    // ------------------------------------------------------------------------
    // address map and widths
    // ------------------------------------------------------------------------

    localparam logic [31:0] addr_red_leds   = 32'h1F80_0000;
    localparam logic [31:0] addr_green_leds = 32'h1F80_0004;
    localparam logic [31:0] addr_switches   = 32'h1F80_0008;
    localparam logic [31:0] addr_buttons    = 32'h1F80_000C;

    localparam int switch_count    = 10;
    localparam int button_count    = 4;
    localparam int red_led_count   = 18;
    localparam int green_led_count = 9;

    localparam int debounce_cycles = 4; // stable cycles before output follows.

endpackage

`default_nettype wire

/* design/mfp_seven_segment_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module mfp_seven_segment_bank
(
    input  logic                          clk,
    input  logic                          reset,
    input  mfp_display_pkg::nibble_bank_t nibbles,
    output mfp_display_pkg::digit_bank_t  hex
);

    import mfp_display_pkg::*;

    digit_bank_t decoded;

    // ------------------------------------------------------------------------
    // decode all digits in parallel
    // ------------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < digit_count; i++) begin
            decoded[i] = hex_to_segments(nibbles[i]);
        end
    end

    // ------------------------------------------------------------------------
    // display register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset)
            hex <= {digit_count{hex_to_segments(4'h0)}}; // every digit shows 0.
        else
            hex <= decoded;
    end

endmodule

`default_nettype wire

/* design/mfp_switch_debouncer.sv */
`timescale 1ns/1ns
`default_nettype none

module mfp_switch_debouncer
#(
    parameter int WIDTH = 1
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] sw_in,
    output logic [WIDTH-1:0] sw_out
);

    import mfp_io_pkg::*;

    localparam int count_width = $clog2(debounce_cycles) + 1;

    logic [WIDTH-1:0] sync_1;
    logic [WIDTH-1:0] sync_2;

    // two-flop synchronizer for the asynchronous board inputs.
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= sw_in;
            sync_2 <= sync_1;
        end
    end

    // each bit has its own stability counter.
    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
        logic [count_width-1:0] count;

        always_ff @(posedge clk) begin
            if (reset) begin
                count     <= '0;
                sw_out[i] <= 1'b0;
            end else if (sync_2[i] == sw_out[i]) begin
                count <= '0; // bounce back restarts the wait.
            end else if (count == count_width'(debounce_cycles - 1)) begin
                count     <= '0;
                sw_out[i] <= sync_2[i];
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/board_io_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module board_io_properties
(
    input logic                                   clk,
    input logic                                   reset,
    input mfp_io_pkg::bus_req_t                   bus_req,
    input mfp_io_pkg::bus_rsp_t                   bus_rsp,
    input logic [mfp_io_pkg::red_led_count-1:0]   red_leds,
    input logic [mfp_io_pkg::green_led_count-1:0] green_leds
);

    logic read_req;

    assign read_req = bus_req.valid && !bus_req.write;

    // every read is answered on the following cycle.
    read_gets_response: assert property (
        @(posedge clk) disable iff (reset) read_req |=> bus_rsp.valid
    ) else $error("read request not answered on the next cycle");

    // writes, idle cycles and reset produce no response.
    no_stray_response: assert property (
        @(posedge clk) (reset || !read_req) |=> !bus_rsp.valid
    ) else $error("response without a read request");

    leds_cleared_by_reset: assert property (
        @(posedge clk) reset |=> (red_leds == '0 && green_leds == '0)
    ) else $error("led registers not cleared after reset");

endmodule

`default_nettype wire

/* dv/board_io_stim.txt */
# op arg value, hex. W write addr data, R read addr expected, S set sw key, G glitch sw
# H check display with digits 5..0 in value, L check ledr against value
L 0 0
H 0 000000
R 1F800000 0
W 1F800000 FFFABCDE
W 1F800004 FFFFF1A5
L 0 1A5
H 0 12BCDE
R 1F800000 2BCDE
R 1F800004 1A5
R 1F800008 0
R 1F80000C 0
W 1F800008 3FF
W F0000000 FFFFFFFF
L 0 1A5
H 0 F2BCDE
R F0000000 0
R 1F800000 2BCDE
R 1F800004 1A5
S 2A5 A
R 1F800008 2A5
R 1F80000C 5
G 3FF 0
R 1F800008 2A5
H 0 12BCDE

/* dv/tb_board_io.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_board_io;

    import mfp_io_pkg::*;
    import mfp_display_pkg::*;

    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] arg;
        logic [31:0] value;
    } stim_step_t;

    localparam bus_req_t idle_req = '0;

    // active-low patterns from F down to 0.
    localparam logic [15:0][6:0] seg_table = {
        7'b0001110, 7'b0000110, 7'b0100001, 7'b1000110,
        7'b0000011, 7'b0001000, 7'b0010000, 7'b0000000,
        7'b1111000, 7'b0000010, 7'b0010010, 7'b0011001,
        7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000
    };

    logic                    clk;
    logic                    reset;
    logic [switch_count-1:0] sw;
    logic [button_count-1:0] key;
    bus_req_t                bus_req;
    bus_rsp_t                bus_rsp;
    logic [9:0]              ledr;
    digit_bank_t             hex;

    stim_step_t steps[$];
    bus_rsp_t   rsp_expected;        // response due at the next clock.
    int         cycle_count = 0;
    int         cycle_limit = 1000;

    mfp_board_io dut (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .sw      ( sw      ),
        .key     ( key     ),
        .bus_req ( bus_req ),
        .bus_rsp ( bus_rsp ),
        .ledr    ( ledr    ),
        .hex     ( hex     )
    );

    bind mfp_gpio_registers board_io_properties props (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .bus_req    ( bus_req    ),
        .bus_rsp    ( bus_rsp    ),
        .red_leds   ( red_leds   ),
        .green_leds ( green_leds )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > cycle_limit)
                abort_run($sformatf("timeout: run still busy after %0d cycles", cycle_count));
        end
    end

    // ------------------------------------------------------------------------
    // helpers and compare tasks
    // ------------------------------------------------------------------------

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    function automatic bus_req_t make_req(input logic write, input logic [31:0] addr,
                                          input logic [31:0] wdata);
        bus_req_t req;
        req.valid = 1'b1;
        req.write = write;
        req.addr  = addr;
        req.wdata = wdata;
        return req;
    endfunction

    function automatic digit_bank_t expected_display(input logic [23:0] digits);
        digit_bank_t bank;
        for (int i = 0; i < digit_count; i++) begin
            bank[i] = seg_table[digits[4*i +: 4]];
        end
        return bank;
    endfunction

    task automatic check_rdata(input bus_rsp_t expected, input bus_rsp_t actual);
        if (actual.valid !== expected.valid)
            abort_run($sformatf("Error at %0t ns: bus_rsp.valid expected %b, got %b",
                                $time, expected.valid, actual.valid));
        else if (expected.valid && actual.rdata !== expected.rdata)
            abort_run($sformatf("Error at %0t ns: bus_rsp.rdata expected %h, got %h",
                                $time, expected.rdata, actual.rdata));
    endtask

    task automatic check_hex(input digit_bank_t expected, input digit_bank_t actual);
        if (actual !== expected)
            abort_run($sformatf("Error at %0t ns: hex expected %h, got %h",
                                $time, expected, actual));
    endtask

    task automatic check_ledr(input logic [9:0] expected, input logic [9:0] actual);
        if (actual !== expected)
            abort_run($sformatf("Error at %0t ns: ledr expected %h, got %h",
                                $time, expected, actual));
    endtask

    // check the response owed by the last cycle, then drive the next request.
    task automatic step_cycle(input bus_req_t req, input logic [31:0] read_data);
        @(posedge clk);
        #2;
        check_rdata(rsp_expected, bus_rsp);
        bus_req            = req;
        rsp_expected.valid = req.valid && !req.write;
        rsp_expected.rdata = rsp_expected.valid ? read_data : 32'h0;
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) step_cycle(idle_req, 32'h0);
    endtask

    task automatic load_stimulus();
        int         fd;
        int         fields;
        string      line;
        logic [7:0] op;
        logic [31:0] arg;
        logic [31:0] value;
        fd = $fopen("dv/board_io_stim.txt", "r");
        if (fd == 0)
            abort_run("could not open dv/board_io_stim.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() <= 1 || line[0] == "#")
                continue;
            fields = $sscanf(line, "%c %h %h", op, arg, value);
            if (fields != 3)
                abort_run($sformatf("malformed line in stim file: %s", line));
            steps.push_back({op, arg, value});
        end
        $fclose(fd);
    endtask

    task automatic run_step(input stim_step_t s);
        logic [switch_count-1:0] held_sw;
        case (s.op)
            "W": begin
                step_cycle(make_req(1'b1, s.arg, s.value), 32'h0);
                wait_cycles(2); // display lags the write by two cycles.
            end
            "R": step_cycle(make_req(1'b0, s.arg, 32'h0), s.value);
            "S": begin
                sw  = s.arg[switch_count-1:0];
                key = s.value[button_count-1:0];
                wait_cycles(10);
            end
            "G": begin
                held_sw = sw;
                sw      = s.arg[switch_count-1:0];
                step_cycle(idle_req, 32'h0);
                sw      = held_sw; // back after a single cycle.
                // the switch register is read on every cycle the glitch could show.
                repeat (10) step_cycle(make_req(1'b0, addr_switches, 32'h0), 32'(held_sw));
            end
            "H": check_hex(expected_display(s.value[23:0]), hex);
            "L": check_ledr(s.value[9:0], ledr);
            default: abort_run($sformatf("unknown operation %c in stim file", s.op));
        endcase
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        reset        = 1'b1;
        sw           = '0;
        key          = '1; // no key pressed.
        bus_req      = idle_req;
        rsp_expected = '0;
        load_stimulus();
        cycle_limit = 20 * steps.size() + 50;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        step_cycle(idle_req, 32'h0); // collects the last read.
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
design/mfp_io_pkg.sv
design/mfp_display_pkg.sv
design/mfp_switch_debouncer.sv
design/mfp_gpio_registers.sv
design/mfp_seven_segment_bank.sv
design/mfp_board_io.sv
dv/board_io_properties.sv
dv/tb_board_io.sv
